// File: verilog/l1_bridge_pkg.sv
// Shared widths, types, latencies and FSM states for the Wishbone to L1 line bridge
`default_nettype none

package l1_bridge_pkg;

    // Wishbone side
    localparam int ADDR_W = 16;
    localparam int WORD_W = 64;
    localparam int SEL_W  = 8;

    // Line side
    localparam int LINE_W         = 256;
    localparam int WORDS_PER_LINE = 4;

    // Cycles of held request before the line store answers
    localparam int LINE_LAT = 3;

    // Cycles the bridge waits on one line access before giving up
    localparam int WAIT_LIMIT = 16;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [SEL_W-1:0]  sel_t;
    typedef logic [LINE_W-1:0] line_t;

    // Word within a line, address bits 4 to 3
    typedef logic [1:0] word_idx_t;

    // Line within the store, address bits 8 to 5
    typedef logic [3:0] line_idx_t;

    // Wide enough to hold WAIT_LIMIT
    typedef logic [4:0] wait_cnt_t;

    typedef enum logic [2:0] {
        Idle,
        ReadLine,
        WriteLine,
        Respond,
        Fault
    } bridge_state_t;

endpackage

`default_nettype wire

// File: verilog/line_wait_timer.sv
// Counts cycles one line access is outstanding and flags when the wait limit is hit
`timescale 1ns/1ps
`default_nettype none

module line_wait_timer (
    input  wire logic i_clk,
    input  wire logic i_nrst,
    input  wire logic i_run,
    output logic      o_expired
);

    import l1_bridge_pkg::*;

    wait_cnt_t wait_cnt;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wait_cnt <= '0;
        end else if (!i_run) begin
            wait_cnt <= '0;
        end else if (wait_cnt != wait_cnt_t'(WAIT_LIMIT)) begin
            // Holds at the limit until the FSM drops run
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign o_expired = (wait_cnt == wait_cnt_t'(WAIT_LIMIT));

endmodule

`default_nettype wire

// File: verilog/line_merge.sv
// Line buffer that captures a fetched line, merges write bytes and picks the reply word
`timescale 1ns/1ps
`default_nettype none

module line_merge (
    input  wire logic                  i_clk,
    input  wire logic                  i_nrst,
    input  wire logic                  i_capture,
    input  wire logic                  i_merge_en,
    input  wire l1_bridge_pkg::line_t  i_line_rdata,
    input  wire l1_bridge_pkg::addr_t  i_wb_adr,
    input  wire l1_bridge_pkg::word_t  i_wb_dat,
    input  wire l1_bridge_pkg::sel_t   i_wb_sel,
    output l1_bridge_pkg::line_t       o_line_wdata,
    output l1_bridge_pkg::word_t       o_wb_dat
);

    import l1_bridge_pkg::*;

    word_idx_t word_idx;
    line_t     merged;
    line_t     line_buf;

    assign word_idx = i_wb_adr[4:3];

    // Replace only the selected bytes of the addressed word
    always_comb begin
        merged = i_line_rdata;
        for (int b = 0; b < SEL_W; b++) begin
            if (i_wb_sel[b]) begin
                merged[word_idx*WORD_W + b*8 +: 8] = i_wb_dat[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            line_buf <= '0;
        end else if (i_capture) begin
            line_buf <= i_merge_en ? merged : i_line_rdata;
        end
    end

    assign o_line_wdata = line_buf;
    assign o_wb_dat     = line_buf[word_idx*WORD_W +: WORD_W];

endmodule

`default_nettype wire

// File: verilog/line_store.sv
// L1 stand-in with sixteen lines, fixed answer latency and an unmapped upper half
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  wire logic                  i_clk,
    input  wire logic                  i_nrst,
    input  wire logic                  i_req,
    input  wire logic                  i_we,
    input  wire l1_bridge_pkg::addr_t  i_adr,
    input  wire l1_bridge_pkg::line_t  i_wdata,
    output logic                       o_ack,
    output l1_bridge_pkg::line_t       o_rdata
);

    import l1_bridge_pkg::*;

    line_t     lines [16];
    line_idx_t line_idx;
    wait_cnt_t lat_cnt;
    logic      mapped;
    logic      answer;

    assign line_idx = i_adr[8:5];

    // Upper half of the address space has no L1 behind it
    assign mapped = !i_adr[15];

    // Last cycle of the latency window
    assign answer = i_req && mapped && !o_ack && (lat_cnt == wait_cnt_t'(LINE_LAT - 1));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            lat_cnt <= '0;
            o_ack   <= 1'b0;
        end else begin
            o_ack <= answer;
            // Count restarts after every answer and whenever the request drops
            if (!i_req || !mapped || o_ack || answer) begin
                lat_cnt <= '0;
            end else begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < 16; i++) begin
                lines[i] <= '0;
            end
        end else if (answer && i_we) begin
            lines[line_idx] <= i_wdata;
        end
    end

    // Read line appears together with the ack
    always_ff @(posedge i_clk) begin
        if (answer && !i_we) begin
            o_rdata <= lines[line_idx];
        end
    end

endmodule

`default_nettype wire

// File: verilog/wb_line_fsm.sv
// Bridge FSM sequencing line read, merge, line write and the Wishbone ack or err reply
`timescale 1ns/1ps
`default_nettype none

module wb_line_fsm (
    input  wire logic i_clk,
    input  wire logic i_nrst,
    input  wire logic i_wb_cyc,
    input  wire logic i_wb_stb,
    input  wire logic i_wb_we,
    input  wire logic i_line_ack,
    input  wire logic i_wait_expired,
    output logic      o_line_req,
    output logic      o_line_we,
    output logic      o_capture,
    output logic      o_merge_en,
    output logic      o_wait_run,
    output logic      o_wb_ack,
    output logic      o_wb_err
);

    import l1_bridge_pkg::*;

    bridge_state_t state;
    bridge_state_t state_next;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= Idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            Idle: begin
                // Every transfer starts with a fetch of the whole line
                if (i_wb_cyc && i_wb_stb) begin
                    state_next = ReadLine;
                end
            end
            ReadLine: begin
                if (i_line_ack) begin
                    state_next = i_wb_we ? WriteLine : Respond;
                end else if (i_wait_expired) begin
                    state_next = Fault;
                end
            end
            WriteLine: begin
                if (i_line_ack) begin
                    state_next = Respond;
                end else if (i_wait_expired) begin
                    state_next = Fault;
                end
            end
            Respond: begin
                state_next = Idle;
            end
            Fault: begin
                state_next = Idle;
            end
            default: begin
                state_next = Idle;
            end
        endcase
    end

    // Request is held for the whole access, ack ends it on the next cycle
    assign o_line_req = (state == ReadLine) || (state == WriteLine);
    assign o_line_we  = (state == WriteLine);

    // Timer stops in the ack cycle so each access is timed on its own
    assign o_wait_run = o_line_req && !i_line_ack;

    // Fetched line lands in the buffer, merged with write bytes on a write
    assign o_capture  = (state == ReadLine) && i_line_ack;
    assign o_merge_en = o_capture && i_wb_we;

    assign o_wb_ack = (state == Respond);
    assign o_wb_err = (state == Fault);

endmodule

`default_nettype wire

// File: verilog/wb_l1_bridge_top.sv
// Top level joining the Wishbone bridge FSM, wait timer, line buffer and line store
`timescale 1ns/1ps
`default_nettype none

module wb_l1_bridge_top (
    input  wire logic                  i_clk,
    input  wire logic                  i_nrst,
    input  wire logic                  i_wb_cyc,
    input  wire logic                  i_wb_stb,
    input  wire logic                  i_wb_we,
    input  wire l1_bridge_pkg::addr_t  i_wb_adr,
    input  wire l1_bridge_pkg::word_t  i_wb_dat,
    input  wire l1_bridge_pkg::sel_t   i_wb_sel,
    output l1_bridge_pkg::word_t       o_wb_dat,
    output logic                       o_wb_ack,
    output logic                       o_wb_err
);

    import l1_bridge_pkg::*;

    logic  line_req;
    logic  line_we;
    logic  line_ack;
    line_t line_rdata;
    line_t line_wdata;
    logic  wait_run;
    logic  wait_expired;
    logic  capture;
    logic  merge_en;

    wb_line_fsm wb_line_fsm_inst (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_line_ack     (line_ack),
        .i_wait_expired (wait_expired),
        .o_line_req     (line_req),
        .o_line_we      (line_we),
        .o_capture      (capture),
        .o_merge_en     (merge_en),
        .o_wait_run     (wait_run),
        .o_wb_ack       (o_wb_ack),
        .o_wb_err       (o_wb_err)
    );

    line_wait_timer line_wait_timer_inst (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_run     (wait_run),
        .o_expired (wait_expired)
    );

    line_merge line_merge_inst (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_capture    (capture),
        .i_merge_en   (merge_en),
        .i_line_rdata (line_rdata),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .i_wb_sel     (i_wb_sel),
        .o_line_wdata (line_wdata),
        .o_wb_dat     (o_wb_dat)
    );

    // Master holds the address stable, so the store takes it directly
    line_store line_store_inst (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_req   (line_req),
        .i_we    (line_we),
        .i_adr   (i_wb_adr),
        .i_wdata (line_wdata),
        .o_ack   (line_ack),
        .o_rdata (line_rdata)
    );

endmodule

`default_nettype wire

// File: tests/wb_l1_bridge_props.sv
// Concurrent checks on the Wishbone and line handshakes, bound into the bridge top level
`timescale 1ns/1ps
`default_nettype none

module wb_l1_bridge_props (
    input wire logic i_clk,
    input wire logic i_nrst,
    input wire logic i_wb_cyc,
    input wire logic i_wb_stb,
    input wire logic i_wb_ack,
    input wire logic i_wb_err,
    input wire logic i_line_req,
    input wire logic i_line_ack,
    input wire logic i_wait_expired
);

    a_reply_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_nrst) !(i_wb_ack && i_wb_err)
    ) else $error("ack and err high in the same cycle");

    // A reply only belongs to an active transfer
    a_reply_in_cycle: assert property (
        @(posedge i_clk) disable iff (!i_nrst) (i_wb_ack || i_wb_err) |-> (i_wb_cyc && i_wb_stb)
    ) else $error("ack or err outside of cyc and stb");

    a_req_held: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (i_line_req && !i_line_ack && !i_wait_expired) |=> i_line_req
    ) else $error("line request dropped before ack or expiry");

    a_reset_quiet: assert property (
        @(posedge i_clk) !i_nrst |-> (!i_wb_ack && !i_wb_err)
    ) else $error("ack or err high during reset");

endmodule

bind wb_l1_bridge_top wb_l1_bridge_props wb_l1_bridge_props_inst (
    .i_clk          (i_clk),
    .i_nrst         (i_nrst),
    .i_wb_cyc       (i_wb_cyc),
    .i_wb_stb       (i_wb_stb),
    .i_wb_ack       (o_wb_ack),
    .i_wb_err       (o_wb_err),
    .i_line_req     (line_req),
    .i_line_ack     (line_ack),
    .i_wait_expired (wait_expired)
);

`default_nettype wire

// File: tests/tb_wb_l1_bridge.sv
// Testbench for the Wishbone to L1 line bridge, runs a stimulus table against a shadow memory
`timescale 1ns/1ps
`default_nettype none

module tb_wb_l1_bridge;

    import l1_bridge_pkg::*;

    localparam logic [31:0] SEED = 32'hce25204a;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_FIXED    = 12;
    localparam int NUM_RANDOM   = 24;
    localparam int NUM_TESTS    = NUM_FIXED + NUM_RANDOM;
    localparam int CYCLE_LIMIT  = NUM_TESTS * (WAIT_LIMIT + 2 * LINE_LAT + 10) + RESET_CYCLES;

    logic  i_clk = 1'b0;
    logic  i_nrst;
    logic  i_wb_cyc;
    logic  i_wb_stb;
    logic  i_wb_we;
    addr_t i_wb_adr;
    word_t i_wb_dat;
    sel_t  i_wb_sel;
    word_t o_wb_dat;
    logic  o_wb_ack;
    logic  o_wb_err;

    // Stimulus table, one transfer per entry
    string name_tab   [NUM_TESTS];
    logic  we_tab     [NUM_TESTS];
    addr_t adr_tab    [NUM_TESTS];
    word_t dat_tab    [NUM_TESTS];
    sel_t  sel_tab    [NUM_TESTS];
    word_t exp_tab    [NUM_TESTS];
    logic  err_tab    [NUM_TESTS];
    logic  shadow_tab [NUM_TESTS];

    // One entry per 64-bit word of the sixteen mapped lines
    word_t  shadow [64];
    integer seed = SEED;
    int     cycle_cnt = 0;
    int     pass_count = 0;
    int     fail_count = 0;

    wb_l1_bridge_top wb_l1_bridge_top_inst (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .i_wb_sel (i_wb_sel),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .o_wb_err (o_wb_err)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the bridge gave no ack or err within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic set_entry(input int idx, input string name, input logic we, input addr_t adr,
                             input word_t dat, input sel_t sel, input word_t exp_dat,
                             input logic exp_err);
        name_tab[idx]   = name;
        we_tab[idx]     = we;
        adr_tab[idx]    = adr;
        dat_tab[idx]    = dat;
        sel_tab[idx]    = sel;
        exp_tab[idx]    = exp_dat;
        err_tab[idx]    = exp_err;
        shadow_tab[idx] = 1'b0;
    endtask

    // Aligned addresses inside the mapped lines only
    task automatic build_random_entries();
        logic [31:0] rnd;
        for (int t = NUM_FIXED; t < NUM_TESTS; t++) begin
            rnd = $random(seed);
            set_entry(t, $sformatf("rand_%0d", t - NUM_FIXED), rnd[8], {7'b0, rnd[5:0], 3'b0},
                      {$random(seed), $random(seed)}, rnd[23:16], '0, 1'b0);
            shadow_tab[t] = 1'b1;
        end
    endtask

    // Bytes under sel replace the stored word, the rest stay
    task automatic apply_write_to_shadow(input int t);
        int w;
        w = int'(adr_tab[t][8:3]);
        for (int b = 0; b < SEL_W; b++) begin
            if (sel_tab[t][b]) begin
                shadow[w][b*8 +: 8] = dat_tab[t][b*8 +: 8];
            end
        end
    endtask

    task automatic do_transfer(input int t, output logic got_err, output word_t got_dat);
        @(posedge i_clk);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= we_tab[t];
        i_wb_adr <= adr_tab[t];
        i_wb_dat <= dat_tab[t];
        i_wb_sel <= sel_tab[t];
        do begin
            @(negedge i_clk);
        end while (!(o_wb_ack || o_wb_err));
        got_err = o_wb_err;
        got_dat = o_wb_dat;
        @(posedge i_clk);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
    endtask

    initial begin : main
        logic  got_err;
        word_t got_dat;
        word_t exp_dat;
        logic  ok;

        i_nrst   = 1'b0;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        i_wb_sel = '0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = '0;
        end

        set_entry(0, "read_unwritten", 1'b0, 16'h0040, '0, 8'hff, 64'h0, 1'b0);
        set_entry(1, "write_full", 1'b1, 16'h0008, 64'h1122334455667788, 8'hff, '0, 1'b0);
        set_entry(2, "read_full", 1'b0, 16'h0008, '0, 8'hff, 64'h1122334455667788, 1'b0);
        set_entry(3, "write_partial", 1'b1, 16'h0008, 64'haaaaaaaaaaaaaaaa, 8'h0f, '0, 1'b0);
        // Low four bytes replaced, upper four kept from the full write
        set_entry(4, "read_partial", 1'b0, 16'h0008, '0, 8'hff, 64'h11223344aaaaaaaa, 1'b0);
        set_entry(5, "write_word0", 1'b1, 16'h0060, 64'h0101010101010101, 8'hff, '0, 1'b0);
        set_entry(6, "write_word3", 1'b1, 16'h0078, 64'h0303030303030303, 8'hff, '0, 1'b0);
        set_entry(7, "read_word0", 1'b0, 16'h0060, '0, 8'hff, 64'h0101010101010101, 1'b0);
        set_entry(8, "read_word3", 1'b0, 16'h0078, '0, 8'hff, 64'h0303030303030303, 1'b0);
        set_entry(9, "read_unmapped", 1'b0, 16'h8000, '0, 8'hff, '0, 1'b1);
        set_entry(10, "write_unmapped", 1'b1, 16'h8010, 64'hdeadbeefdeadbeef, 8'hff, '0, 1'b1);
        set_entry(11, "read_after_err", 1'b0, 16'h0008, '0, 8'hff, 64'h11223344aaaaaaaa, 1'b0);
        build_random_entries();

        repeat (RESET_CYCLES) @(posedge i_clk);
        i_nrst <= 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            do_transfer(t, got_err, got_dat);
            exp_dat = shadow_tab[t] ? shadow[adr_tab[t][8:3]] : exp_tab[t];
            ok = 1'b1;
            assert (got_err == err_tab[t]) else begin
                $display("Fail %s: expected err %0b, actual err %0b",
                         name_tab[t], err_tab[t], got_err);
                ok = 1'b0;
            end
            if (ok && !we_tab[t] && !err_tab[t]) begin
                assert (got_dat == exp_dat) else begin
                    $display("Fail %s: expected %h, actual %h", name_tab[t], exp_dat, got_dat);
                    ok = 1'b0;
                end
            end
            if (we_tab[t] && !err_tab[t]) begin
                apply_write_to_shadow(t);
            end
            if (ok) begin
                pass_count++;
                $display("Pass %s", name_tab[t]);
            end else begin
                fail_count++;
            end
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d", NUM_TESTS, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/l1_bridge_pkg.sv
verilog/line_wait_timer.sv
verilog/line_merge.sv
verilog/line_store.sv
verilog/wb_line_fsm.sv
verilog/wb_l1_bridge_top.sv
tests/wb_l1_bridge_props.sv
tests/tb_wb_l1_bridge.sv

// File: Makefile
TOP := tb_wb_l1_bridge
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run reported failure"; exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Run ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
